// ==== hw/board_pkg.sv ====
// shared widths, timing defaults and bus types for the fabric side of the board top, imported by every hw module
`default_nettype none

package board_pkg;

	// ====================================================================
	// host bus and register bank
	// ====================================================================
	localparam int addr_width  = 14;        // word address from the bridge
	localparam int bus_width   = 32;        // host data bus
	localparam int num_reg     = 6;         // writable bank, addr 0..5
	localparam int status_addr = 6;         // read only, first slot past the bank
	localparam int oe_width    = 34;        // 24 bits of reg 0 plus 10 of reg 1

	// board i/o counts
	localparam int num_keys = 2;            // push keys, active low on the pins
	localparam int sw_width = 4;            // slide switches

	// ====================================================================
	// timing defaults, all in fpga_clk_50 cycles
	// ====================================================================
	localparam int debounce_cycles_default = 50000;      // 1 ms at 50 mhz
	localparam int heartbeat_half_default  = 25000000;   // half a second per led phase

	// reset request stretch lengths
	// each hps reset input wants its own minimum width
	localparam int cold_pulse_len  = 6;
	localparam int warm_pulse_len  = 2;
	localparam int debug_pulse_len = 32;

	// ====================================================================
	// types
	// ====================================================================

	// host access, write and read never high together
	typedef struct packed {
		logic                  write;   // one cycle write strobe
		logic                  read;    // one cycle read strobe
		logic [addr_width-1:0] addr;    // word address
		logic [bus_width-1:0]  wdata;   // only looked at with write
	} host_req_t;

	// raw request levels, one per hps reset input
	typedef struct packed {
		logic cold;
		logic warm;
		logic debug;
	} reset_req_t;

	// stretched pulses towards the hps, low while asserted
	typedef struct packed {
		logic cold_n;
		logic warm_n;
		logic debug_n;
	} reset_pulse_t;

	// pulse stretcher states
	typedef enum logic [1:0] {
		idle     = 2'd0,    // armed, waiting for req
		stretch  = 2'd1,    // pulse_n held low
		wait_low = 2'd2     // req still high after the pulse
	} reset_fsm_state_t;

endpackage

`default_nettype wire

// ==== hw/key_debounce.sv ====
// stability timer per push key, turns the raw active-low pins into clean pressed levels for the top
`default_nettype none

module key_debounce #(
	parameter int cycles = board_pkg::debounce_cycles_default   // stable cycles before a flip
) (
	input  logic                           fpga_clk_50,
	input  logic                           hps_fpga_reset_n,
	input  logic [board_pkg::num_keys-1:0] key,           // raw pins, low when pressed
	output logic [board_pkg::num_keys-1:0] key_pressed    // debounced, 1 when pressed
);
	import board_pkg::*;

	// counter just wide enough for the stability window
	localparam int                   cnt_width = $clog2(cycles + 1);
	localparam logic [cnt_width-1:0] cnt_last  = cnt_width'(cycles - 1);

	logic [num_keys-1:0]  raw_pressed;            // pin level flipped to pressed = 1
	logic [cnt_width-1:0] stable_cnt [num_keys];  // cycles the pin has disagreed with the output
	logic [num_keys-1:0]  differs;                // raw level vs current output
	logic [num_keys-1:0]  window_done;            // last cycle of the window

	assign raw_pressed = ~key;
	assign differs     = raw_pressed ^ key_pressed;

	// ====================================================================
	// per key compare
	// ====================================================================
	always_comb
	begin
		for (int k = 0; k < num_keys; k++)
		begin
			window_done[k] = differs[k] && (stable_cnt[k] == cnt_last);
		end
	end

	// ====================================================================
	// stability counters and output levels
	// ====================================================================
	// any bounce back to the old level clears the count,
	// so only an unbroken run of cycles can flip the output
	always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
	begin
		if (!hps_fpga_reset_n)
		begin
			for (int k = 0; k < num_keys; k++)
			begin
				stable_cnt[k] <= '0;
			end
			key_pressed <= '0;                      // nothing pressed out of reset
		end
		else
		begin
			for (int k = 0; k < num_keys; k++)
			begin
				if (!differs[k])
				begin
					stable_cnt[k] <= '0;            // levels agree, idle
				end
				else if (window_done[k])
				begin
					stable_cnt[k]  <= '0;
					key_pressed[k] <= raw_pressed[k];   // held long enough, take it
				end
				else
				begin
					stable_cnt[k] <= stable_cnt[k] + 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== hw/reset_pulse_fsm.sv ====
// small fsm that stretches the rising edge of one reset request into a fixed-length active-low pulse
`default_nettype none

module reset_pulse_fsm #(
	parameter int pulse_len = board_pkg::cold_pulse_len   // low time in cycles
) (
	input  logic fpga_clk_50,
	input  logic hps_fpga_reset_n,
	input  logic req,        // request level, high = asserted
	output logic pulse_n     // stretched pulse, low while asserted
);
	import board_pkg::*;

	localparam int                   len_width = $clog2(pulse_len + 1);
	localparam logic [len_width-1:0] len_last  = len_width'(pulse_len - 1);

	reset_fsm_state_t     state_q;
	reset_fsm_state_t     state_d;
	logic [len_width-1:0] len_cnt;     // cycles spent in stretch
	logic                 len_done;    // last low cycle

	assign len_done = (len_cnt == len_last);

	// ====================================================================
	// next state
	// ====================================================================
	always_comb
	begin
		state_d = state_q;
		case (state_q)
			idle:
			begin
				if (req)
					state_d = stretch;       // pulse starts next cycle
			end
			stretch:
			begin
				// req is ignored until the pulse has run its length
				if (len_done)
					state_d = req ? wait_low : idle;
			end
			wait_low:
			begin
				if (!req)
					state_d = idle;          // re-armed only after a low sample
			end
			default:
			begin
				state_d = idle;              // unused encoding
			end
		endcase
	end

	always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
	begin
		if (!hps_fpga_reset_n)
			state_q <= idle;
		else
			state_q <= state_d;
	end

	// ====================================================================
	// length counter, runs in stretch only
	// ====================================================================
	always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
	begin
		if (!hps_fpga_reset_n)
		begin
			len_cnt <= '0;
		end
		else if ((state_q == stretch) && !len_done)
		begin
			len_cnt <= len_cnt + 1'b1;
		end
		else
		begin
			len_cnt <= '0;                   // parked at zero for the next entry
		end
	end

	// straight decode of the state register
	assign pulse_n = (state_q != stretch);

endmodule

`default_nettype wire

// ==== hw/heartbeat_divider.sv ====
// blink divider for the heartbeat led, toggles once every half_period clock cycles
`default_nettype none

module heartbeat_divider #(
	parameter int half_period = board_pkg::heartbeat_half_default   // cycles per led phase
) (
	input  logic fpga_clk_50,
	input  logic hps_fpga_reset_n,
	output logic led            // heartbeat level
);

	localparam int                   div_width = $clog2(half_period + 1);
	localparam logic [div_width-1:0] div_last  = div_width'(half_period - 1);

	logic [div_width-1:0] div_cnt;    // cycles into the current phase

	// first toggle lands half_period cycles after reset lifts
	always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
	begin
		if (!hps_fpga_reset_n)
		begin
			div_cnt <= '0;
			led     <= 1'b0;
		end
		else if (div_cnt == div_last)
		begin
			div_cnt <= '0;           // wrap
			led     <= ~led;         // and flip
		end
		else
		begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== hw/gpio_oe_regs.sv ====
// host register bank with write decode, one-cycle read path, status word and the gpio output-enable word
`default_nettype none

module gpio_oe_regs (
	input  logic                            fpga_clk_50,
	input  logic                            hps_fpga_reset_n,
	input  board_pkg::host_req_t            host_req,      // strobes, address, write data
	input  logic [board_pkg::sw_width-1:0]  sw,            // slide switches
	input  logic [board_pkg::num_keys-1:0]  key_pressed,   // debounced keys
	input  logic                            led,           // heartbeat
	output logic [board_pkg::bus_width-1:0] rdata,
	output logic                            rdata_valid,   // one cycle after the read strobe
	output logic [board_pkg::oe_width-1:0]  gpio_oe
);
	import board_pkg::*;

	logic [bus_width-1:0] regs_q [num_reg];   // the bank
	logic [num_reg-1:0]   wr_sel;             // one hot write select
	logic [bus_width-1:0] status_word;
	logic [bus_width-1:0] rd_mux;

	// ====================================================================
	// write decode
	// ====================================================================
	// addresses at or above num_reg match nothing and fall away
	always_comb
	begin
		for (int r = 0; r < num_reg; r++)
		begin
			wr_sel[r] = host_req.write && (host_req.addr == addr_width'(r));
		end
	end

	always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
	begin
		if (!hps_fpga_reset_n)
		begin
			for (int r = 0; r < num_reg; r++)
			begin
				regs_q[r] <= '0;
			end
		end
		else
		begin
			for (int r = 0; r < num_reg; r++)
			begin
				if (wr_sel[r])
					regs_q[r] <= host_req.wdata;   // lands at the strobe edge
			end
		end
	end

	// ====================================================================
	// read path
	// ====================================================================
	// same packing as the old stm event vector, keys at the bottom
	assign status_word = {{(bus_width - sw_width - 1 - num_keys){1'b0}}, sw, led, key_pressed};

	always_comb
	begin
		rd_mux = '0;                               // unmapped reads give zero
		if (host_req.addr == addr_width'(status_addr))
			rd_mux = status_word;
		for (int r = 0; r < num_reg; r++)
		begin
			if (host_req.addr == addr_width'(r))
				rd_mux = regs_q[r];
		end
	end

	// data only loads on a read, valid marks it
	always_ff @(posedge fpga_clk_50)
	begin
		if (host_req.read)
			rdata <= rd_mux;
	end

	// valid strobe and oe word, oe trails the bank by one cycle
	always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
	begin
		if (!hps_fpga_reset_n)
		begin
			rdata_valid <= 1'b0;
			gpio_oe     <= '0;
		end
		else
		begin
			rdata_valid <= host_req.read;
			gpio_oe     <= {regs_q[1][9:0], regs_q[0][23:0]};   // 10 high bits over 24 low
		end
	end

endmodule

`default_nettype wire

// ==== hw/de0_nano_gpio_top.sv ====
// fabric top of the board, ties keys, reset requests, heartbeat and the host register bank together
`default_nettype none

module de0_nano_gpio_top #(
	parameter int debounce_cycles = board_pkg::debounce_cycles_default,
	parameter int heartbeat_half  = board_pkg::heartbeat_half_default
) (
	input  logic                            fpga_clk_50,
	input  logic                            hps_fpga_reset_n,   // async, low = reset

	// board inputs
	input  logic [board_pkg::num_keys-1:0]  key,           // push keys, low when pressed
	input  logic [board_pkg::sw_width-1:0]  sw,
	input  board_pkg::reset_req_t           reset_req,     // cold, warm, debug levels

	// host side
	input  board_pkg::host_req_t            host_req,
	output logic [board_pkg::bus_width-1:0] rdata,
	output logic                            rdata_valid,

	// board outputs
	output logic [board_pkg::num_keys-1:0]  key_pressed,   // debounced keys
	output logic                            led,           // heartbeat
	output logic [board_pkg::oe_width-1:0]  gpio_oe,       // gpio output enables
	output board_pkg::reset_pulse_t         reset_pulse    // stretched, active low
);
	import board_pkg::*;

	// ====================================================================
	// keys and heartbeat
	// ====================================================================
	key_debounce #(
		.cycles (debounce_cycles)
	) u_key_debounce (
		.fpga_clk_50      (fpga_clk_50),
		.hps_fpga_reset_n (hps_fpga_reset_n),
		.key              (key),
		.key_pressed      (key_pressed)      // to the pins and the status word
	);

	heartbeat_divider #(
		.half_period (heartbeat_half)
	) u_heartbeat (
		.fpga_clk_50      (fpga_clk_50),
		.hps_fpga_reset_n (hps_fpga_reset_n),
		.led              (led)
	);

	// ====================================================================
	// reset request stretchers, one per hps input
	// ====================================================================
	reset_pulse_fsm #(
		.pulse_len (cold_pulse_len)
	) u_cold_pulse (
		.fpga_clk_50      (fpga_clk_50),
		.hps_fpga_reset_n (hps_fpga_reset_n),
		.req              (reset_req.cold),
		.pulse_n          (reset_pulse.cold_n)
	);

	reset_pulse_fsm #(
		.pulse_len (warm_pulse_len)
	) u_warm_pulse (
		.fpga_clk_50      (fpga_clk_50),
		.hps_fpga_reset_n (hps_fpga_reset_n),
		.req              (reset_req.warm),
		.pulse_n          (reset_pulse.warm_n)
	);

	reset_pulse_fsm #(
		.pulse_len (debug_pulse_len)     // longest, debug core is slow to catch it
	) u_debug_pulse (
		.fpga_clk_50      (fpga_clk_50),
		.hps_fpga_reset_n (hps_fpga_reset_n),
		.req              (reset_req.debug),
		.pulse_n          (reset_pulse.debug_n)
	);

	// host registers
	gpio_oe_regs u_gpio_oe_regs (
		.fpga_clk_50      (fpga_clk_50),
		.hps_fpga_reset_n (hps_fpga_reset_n),
		.host_req         (host_req),
		.sw               (sw),
		.key_pressed      (key_pressed),
		.led              (led),
		.rdata            (rdata),
		.rdata_valid      (rdata_valid),
		.gpio_oe          (gpio_oe)
	);

endmodule

`default_nettype wire

// ==== dv/tb_clk_gen.sv ====
// clock and reset source for the testbench, 4 unit period with reset held low for 3 cycles
`default_nettype none

module tb_clk_gen (
	output logic fpga_clk_50,
	output logic hps_fpga_reset_n
);

	initial
	begin
		fpga_clk_50 = 1'b0;
		forever #2 fpga_clk_50 = ~fpga_clk_50;   // 4 unit period
	end

	initial
	begin
		hps_fpga_reset_n = 1'b0;                  // in reset from time zero
		repeat (3) @(posedge fpga_clk_50);
		@(negedge fpga_clk_50);
		hps_fpga_reset_n = 1'b1;                  // released away from the active edge
	end

endmodule

`default_nettype wire

// ==== dv/tb_top.sv ====
// top testbench, runs the board top through reset, register bank, debounce, reset pulse and heartbeat checks
`default_nettype none

module tb_top;
	import board_pkg::*;

	localparam int debounce_len  = 20;    // dut debounce_cycles
	localparam int heartbeat_len = 50;    // dut heartbeat_half

	logic                 fpga_clk_50;
	logic                 hps_fpga_reset_n;
	logic [num_keys-1:0]  key;
	logic [sw_width-1:0]  sw;
	reset_req_t           reset_req;
	host_req_t            host_req;
	logic [bus_width-1:0] rdata;
	logic                 rdata_valid;
	logic [num_keys-1:0]  key_pressed;
	logic                 led;
	logic [oe_width-1:0]  gpio_oe;
	reset_pulse_t         reset_pulse;

	// reference state
	logic [bus_width-1:0] model_regs [num_reg];   // mirror of the bank
	logic [num_keys-1:0]  exp_keys;               // expected debounced keys
	logic [bus_width-1:0] exp_data_q [$];         // expected read data, in order
	int                   exp_due_q [$];          // cycle where each valid is due
	int                   cycle_cnt = 0;
	int                   release_cycle;

	tb_clk_gen u_clk_gen (
		.fpga_clk_50      (fpga_clk_50),
		.hps_fpga_reset_n (hps_fpga_reset_n)
	);

	de0_nano_gpio_top #(
		.debounce_cycles (debounce_len),
		.heartbeat_half  (heartbeat_len)
	) u_dut (
		.fpga_clk_50      (fpga_clk_50),
		.hps_fpga_reset_n (hps_fpga_reset_n),
		.key              (key),
		.sw               (sw),
		.reset_req        (reset_req),
		.host_req         (host_req),
		.rdata            (rdata),
		.rdata_valid      (rdata_valid),
		.key_pressed      (key_pressed),
		.led              (led),
		.gpio_oe          (gpio_oe),
		.reset_pulse      (reset_pulse)
	);

	always @(posedge fpga_clk_50) cycle_cnt <= cycle_cnt + 1;

	// ====================================================================
	// reference model
	// ====================================================================
	// led level seen by the next rising edge
	// flips every heartbeat_len edges after release
	function automatic logic led_model();
		return logic'(((cycle_cnt - release_cycle) / heartbeat_len) % 2);
	endfunction

	function automatic logic [bus_width-1:0] ref_read(input int unsigned addr);
		if (addr < num_reg)
			return model_regs[addr];
		if (addr == status_addr)
			return {{(bus_width - sw_width - 1 - num_keys){1'b0}}, sw, led_model(), exp_keys};
		return '0;                                // unmapped
	endfunction

	function automatic logic [oe_width-1:0] ref_oe();
		return {model_regs[1][9:0], model_regs[0][23:0]};
	endfunction

	// ====================================================================
	// checking
	// ====================================================================
	task automatic check_value(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		if (got !== exp)
		begin
			$display("ERR %s got 0x%0h expected 0x%0h", name, got, exp);
			$display("TEST FAILED");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("TEST FAILED");
		$fatal(1, "%s", why);
	endtask

	// every valid must match the oldest outstanding read one cycle after its strobe
	always @(negedge fpga_clk_50)
	begin
		if (rdata_valid)
		begin
			if (exp_data_q.size() == 0)
				abort_run("rdata_valid high with no read outstanding");
			else
			begin
				check_value("rdata_valid_cycle", cycle_cnt, exp_due_q.pop_front());
				check_value("rdata", rdata, exp_data_q.pop_front());
			end
		end
		else if (exp_due_q.size() != 0 && exp_due_q[0] <= cycle_cnt)
			abort_run("rdata_valid missing one cycle after a read strobe");
	end

	// ====================================================================
	// host bus and waits
	// ====================================================================
	task automatic wait_for_reset();
		int n;
		n = 0;
		while (hps_fpga_reset_n !== 1'b1)
		begin
			@(posedge fpga_clk_50);
			n++;
			if (n > 10)
				abort_run("reset was never released");
		end
		@(negedge fpga_clk_50);
		release_cycle = cycle_cnt - 1;            // first counting edge already seen
	endtask

	task automatic host_write(input int unsigned addr, input logic [bus_width-1:0] data);
		logic [oe_width-1:0] old_oe;
		old_oe = ref_oe();
		host_req.write = 1'b1;
		host_req.read  = 1'b0;
		host_req.addr  = addr_width'(addr);
		host_req.wdata = data;
		if (addr < num_reg)
			model_regs[addr] = data;              // high addresses fall away
		@(negedge fpga_clk_50);
		host_req = '0;
		check_value("gpio_oe", gpio_oe, old_oe);      // not moved yet at the write edge
		@(negedge fpga_clk_50);
		check_value("gpio_oe", gpio_oe, ref_oe());   // oe one cycle behind the bank
	endtask

	// leaves read high for the caller to clear or reuse
	task automatic host_read(input int unsigned addr);
		host_req.write = 1'b0;
		host_req.read  = 1'b1;
		host_req.addr  = addr_width'(addr);
		host_req.wdata = $urandom;                // junk that must be ignored
		exp_data_q.push_back(ref_read(addr));
		exp_due_q.push_back(cycle_cnt + 1);
		@(negedge fpga_clk_50);
	endtask

	task automatic drain_reads();
		int n;
		n = 0;
		while (exp_data_q.size() != 0)
		begin
			@(negedge fpga_clk_50);
			n++;
			if (n > 10)
				abort_run("read data still outstanding after 10 cycles");
		end
	endtask

	task automatic read_status();
		host_read(status_addr);
		host_req = '0;
		drain_reads();
	endtask

	task automatic run_register_test();
		int unsigned addr;
		for (int i = 0; i < 40; i++)
		begin
			if ($urandom % 5 == 0)
				addr = status_addr + 1 + ($urandom % 16377);   // above status and ignored
			else
				addr = $urandom % num_reg;
			host_write(addr, $urandom);
		end
		for (int a = 0; a <= status_addr + 1; a++)
		begin
			host_read(a);                         // spaced reads
			host_req = '0;
			@(negedge fpga_clk_50);
		end
		for (int i = 0; i < 24; i++)
			host_read($urandom % (status_addr + 3));   // back to back
		host_req = '0;
		drain_reads();
	endtask

	// ====================================================================
	// keys
	// ====================================================================
	task automatic glitch_key(input int k, input int len);
		key[k] = 1'b0;
		for (int i = 0; i < len; i++)
		begin
			@(negedge fpga_clk_50);
			check_value("key_pressed", key_pressed, exp_keys);
		end
		key[k] = 1'b1;
		for (int i = 0; i < debounce_len + 5; i++)
		begin
			@(negedge fpga_clk_50);
			check_value("key_pressed", key_pressed, exp_keys);
		end
	endtask

	task automatic press_key(input int k, input logic pressed);
		int n;
		n = 0;
		key[k] = ~pressed;                        // pins are active low
		while (key_pressed[k] !== pressed)
		begin
			@(negedge fpga_clk_50);
			n++;
			if (n > debounce_len + 4)
				abort_run("key_pressed did not follow a held key");
		end
		exp_keys[k] = pressed;
		check_value("key_pressed_delay", n, debounce_len);
	endtask

	// ====================================================================
	// reset pulses
	// ====================================================================
	task automatic set_req(input int which, input logic level);
		case (which)
			0:       reset_req.cold  = level;
			1:       reset_req.warm  = level;
			default: reset_req.debug = level;
		endcase
	endtask

	function automatic logic pulse_level(input int which);
		case (which)
			0:       return reset_pulse.cold_n;
			1:       return reset_pulse.warm_n;
			default: return reset_pulse.debug_n;
		endcase
	endfunction

	// one request shape over a window, then count low cycles and falling edges
	task automatic check_pulse(input int which, input int len, input bit hold);
		int   lows;
		int   falls;
		logic prev;
		lows  = 0;
		falls = 0;
		prev  = 1'b1;
		for (int i = 0; i < len + 12; i++)
		begin
			if (hold)
				set_req(which, i < len + 6);      // held past the pulse end
			else
				set_req(which, (i == 0) || (i == 1 + len / 2));   // second edge mid pulse
			@(negedge fpga_clk_50);
			if (!pulse_level(which))
			begin
				lows++;
				if (prev)
					falls++;
			end
			prev = pulse_level(which);
		end
		set_req(which, 1'b0);
		check_value("reset_pulse_low_cycles", lows, len);
		check_value("reset_pulse_falling_edges", falls, 1);
		check_value("reset_pulse", reset_pulse, 3'b111);
	endtask

	// gaps between toggles with the first partial gap skipped
	task automatic run_heartbeat_test();
		int   n;
		logic prev;
		for (int g = 0; g < 4; g++)
		begin
			prev = led;
			n    = 0;
			while (led === prev)
			begin
				@(negedge fpga_clk_50);
				n++;
				check_value("led", led, led_model());
				if (n > heartbeat_len + 10)
					abort_run("led stopped toggling");
			end
			if (g > 0)
				check_value("led_toggle_gap", n, heartbeat_len);
		end
	endtask

	// ====================================================================
	// main sequence
	// ====================================================================
	initial
	begin
		void'($urandom(32'h1f971d77));
		key        = '1;                          // nothing pressed
		sw         = '0;
		reset_req  = '0;
		host_req   = '0;
		exp_keys   = '0;
		for (int r = 0; r < num_reg; r++)
			model_regs[r] = '0;
		wait_for_reset();

		check_value("rdata_valid", rdata_valid, 1'b0);
		check_value("key_pressed", key_pressed, '0);
		check_value("led", led, 1'b0);
		check_value("gpio_oe", gpio_oe, '0);
		check_value("reset_pulse", reset_pulse, 3'b111);

		sw = sw_width'($urandom);
		run_register_test();

		for (int i = 0; i < 6; i++)
			glitch_key(i % num_keys, 1 + ($urandom % 10));
		press_key(0, 1'b1);
		read_status();
		press_key(1, 1'b1);
		read_status();
		press_key(0, 1'b0);
		press_key(1, 1'b0);
		read_status();

		check_pulse(0, cold_pulse_len, 1'b0);
		check_pulse(1, warm_pulse_len, 1'b0);
		check_pulse(2, debug_pulse_len, 1'b0);
		check_pulse(0, cold_pulse_len, 1'b1);
		check_pulse(1, warm_pulse_len, 1'b1);
		check_pulse(2, debug_pulse_len, 1'b1);

		run_heartbeat_test();
		drain_reads();
		$display("TEST PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
hw/board_pkg.sv
hw/key_debounce.sv
hw/reset_pulse_fsm.sv
hw/heartbeat_divider.sv
hw/gpio_oe_regs.sv
hw/de0_nano_gpio_top.sv
dv/tb_clk_gen.sv
dv/tb_top.sv

// ==== Makefile ====
# verilator build and run of tb_top
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build tb_top with verilator, run it and check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"

test:
	verilator --binary --timing -Wno-fatal -f verilog.f --top-module tb_top -Mdir obj_dir -o tb_top
	./obj_dir/tb_top 2>&1 | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation reported a failure"; exit 1; fi
	@grep -q "TEST PASSED" $(LOG) || (echo "no pass line in $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
